// File: store_iq_golden.txt
# D rob sq memop imm rs1_rdy rs1 rs2_rdy rs2 | W en p0 p1 | R rob | I n | S on | F full
# P rs1_en rs2_en | A sq size rob imm | E sq size rob ; all numbers hex
A 01 2 00 123
E 01 2 00
D 00 01 2 123 1 10 1 11
I 6
A 02 1 01 044
E 02 1 01
D 01 02 1 044 0 20 0 21
I 1
P 0 0
W 1 20 00
I 1
P 1 0
W 2 00 21
I 6
A 03 0 02 010
A 04 2 03 020
A 05 1 04 030
E 03 0 02
E 04 2 03
E 05 1 04
D 02 03 0 010 0 30 0 31
D 03 04 2 020 0 30 0 31
D 04 05 1 030 0 30 0 31
W 3 30 31
I 10
A 06 2 0a 100
A 07 1 0b 104
A 08 0 0c 108
A 09 2 0d 10c
A 0a 1 0e 110
A 0b 0 0f 114
A 0c 2 10 118
A 0d 1 11 11c
E 06 2 0a
E 07 1 0b
E 08 0 0c
E 09 2 0d
E 0a 1 0e
E 0b 0 0f
E 0c 2 10
E 0d 1 11
D 0a 06 2 100 1 51 0 50
D 0b 07 1 104 1 51 0 50
D 0c 08 0 108 1 51 0 50
D 0d 09 2 10c 1 51 0 50
D 0e 0a 1 110 1 51 0 50
D 0f 0b 0 114 1 51 0 50
D 10 0c 2 118 1 51 0 50
D 11 0d 1 11c 1 51 0 50
I 1
F 1
D 12 0e 2 1ff 1 52 1 53
W 2 00 50
I 2
F 0
S 1
I 1e
S 0
A 0e 2 1c 200
A 0f 2 1e 204
E 0e 2 1c
E 0f 2 1e
D 1c 0e 2 200 0 60 0 61
D 1e 0f 2 204 0 60 0 61
D 20 10 2 208 0 60 0 61
D 21 11 2 20c 0 60 0 61
I 1
R 20
W 3 60 61
I 8
D 20 12 0 300 1 62 1 63
I 1
R 20
A 13 1 20 304
E 13 1 20
D 20 13 1 304 1 64 1 65
I 8

// File: list.f
store_iq_pkg.sv
oldest_selector.sv
store_issue_bank.sv
store_issue_queue.sv
store_issue_queue_assertions.sv
tb_store_issue_queue.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_store_issue_queue
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb_store_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_store_issue_queue
    import store_iq_pkg::*;
();

    logic                    clk;
    logic                    rst;
    logic                    dispatch;
    logic                    rs1_ready;
    logic                    rs2_ready;
    preg_t                   rs1;
    preg_t                   rs2;
    rob_idx_t                rob_idx;
    sq_idx_t                 sq_idx;
    logic [1:0]              memop;
    logic [IMM_W-1:0]        imm;
    logic                    full;
    logic [WAKEUP_PORTS-1:0] wakeup_en;
    preg_t [WAKEUP_PORTS-1:0] wakeup_preg;
    logic                    redirect;
    rob_idx_t                redirect_rob;
    logic                    rs1_read_en;
    preg_t                   rs1_read_preg;
    logic                    rs1_read_ready;
    logic                    rs2_read_en;
    preg_t                   rs2_read_preg;
    logic                    rs2_read_ready;
    logic                    addr_issue;
    addr_payload_t           addr_issue_payload;
    logic                    data_issue;
    data_payload_t           data_issue_payload;

    string         cmd_q[$];
    logic [31:0]   arg_q[$]; // eight words per command, unused ones are zero
    addr_payload_t addr_exp_q[$];
    data_payload_t data_exp_q[$];
    logic          stall;
    logic [31:0]   lfsr;
    int            cycle_count;
    int            cycle_limit;
    preg_t         rs1_of_rob [64]; // operand pregs given at dispatch, by ROB index
    preg_t         rs2_of_rob [64];
    preg_t         rs1_seen [2];    // read preg one and two cycles back
    preg_t         rs2_seen [2];

    store_issue_queue dut0 (
        .clk                  (clk),
        .rst                  (rst),
        .dispatch_i           (dispatch),
        .rs1_ready_i          (rs1_ready),
        .rs2_ready_i          (rs2_ready),
        .rs1_i                (rs1),
        .rs2_i                (rs2),
        .rob_idx_i            (rob_idx),
        .sq_idx_i             (sq_idx),
        .memop_i              (memop),
        .imm_i                (imm),
        .full_o               (full),
        .wakeup_en_i          (wakeup_en),
        .wakeup_preg_i        (wakeup_preg),
        .redirect_i           (redirect),
        .redirect_rob_i       (redirect_rob),
        .rs1_read_en_o        (rs1_read_en),
        .rs1_read_preg_o      (rs1_read_preg),
        .rs1_read_ready_i     (rs1_read_ready),
        .rs2_read_en_o        (rs2_read_en),
        .rs2_read_preg_o      (rs2_read_preg),
        .rs2_read_ready_i     (rs2_read_ready),
        .addr_issue_o         (addr_issue),
        .addr_issue_payload_o (addr_issue_payload),
        .data_issue_o         (data_issue),
        .data_issue_payload_o (data_issue_payload)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure("value mismatch");
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int arg_count(input string c);
        case (c)
            "D": return 8;
            "W", "A": return (c == "A") ? 4 : 3;
            "E": return 3;
            "P": return 2;
            default: return 1;
        endcase
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        dispatch  = 1'b0;
        wakeup_en = '0;
        redirect  = 1'b0;
        if (stall) begin
            lfsr           = lfsr_step(lfsr);
            rs2_read_ready = lfsr[0];
        end else begin
            rs2_read_ready = 1'b1;
        end
    endtask

    task automatic run_command(input int k);
        logic [31:0]   a [8];
        addr_payload_t ea;
        data_payload_t ed;
        for (int j = 0; j < 8; j++) begin
            a[j] = arg_q[k*8 + j];
        end
        case (cmd_q[k])
            "D": begin
                next_cycle();
                dispatch  = 1'b1;
                rob_idx   = a[0][5:0];
                sq_idx    = a[1][4:0];
                memop     = a[2][1:0];
                imm       = a[3][11:0];
                rs1_ready = a[4][0];
                rs1       = a[5][6:0];
                rs2_ready = a[6][0];
                rs2       = a[7][6:0];
                rs1_of_rob[a[0][5:0]] = a[5][6:0];
                rs2_of_rob[a[0][5:0]] = a[7][6:0];
                #1;
            end
            "W": begin
                next_cycle();
                wakeup_en      = a[0][1:0];
                wakeup_preg[0] = a[1][6:0];
                wakeup_preg[1] = a[2][6:0];
                #1;
            end
            "R": begin
                next_cycle();
                redirect     = 1'b1;
                redirect_rob = a[0][5:0];
                #1;
            end
            "I": begin
                repeat (a[0]) begin
                    next_cycle();
                    #1;
                end
            end
            "S": stall = a[0][0];
            "F": check_value("full_o", 32'(full), a[0]);
            "P": begin
                check_value("rs1_read_en_o", 32'(rs1_read_en), a[0]);
                check_value("rs2_read_en_o", 32'(rs2_read_en), a[1]);
            end
            "A": begin
                ea.sq_idx  = a[0][4:0];
                ea.size    = a[1][1:0];
                ea.rob_idx = a[2][5:0];
                ea.imm     = a[3][11:0];
                addr_exp_q.push_back(ea);
            end
            "E": begin
                ed.sq_idx  = a[0][4:0];
                ed.size    = a[1][1:0];
                ed.rob_idx = a[2][5:0];
                data_exp_q.push_back(ed);
            end
            default: stop_with_failure("unknown command in golden file");
        endcase
    endtask

    // issue outputs come from flops, so they are steady at the falling edge
    always @(negedge clk) begin
        addr_payload_t ea;
        data_payload_t ed;
        if (!rst && addr_issue) begin
            if (addr_exp_q.size() == 0) begin
                stop_with_failure("addr issue came out with no expected record");
            end else begin
                ea = addr_exp_q.pop_front();
                check_value("addr_issue_payload_o.sq_idx", 32'(addr_issue_payload.sq_idx),
                            32'(ea.sq_idx));
                check_value("addr_issue_payload_o.size", 32'(addr_issue_payload.size),
                            32'(ea.size));
                check_value("addr_issue_payload_o.rob_idx", 32'(addr_issue_payload.rob_idx),
                            32'(ea.rob_idx));
                check_value("addr_issue_payload_o.imm", 32'(addr_issue_payload.imm),
                            32'(ea.imm));
                check_value("rs1_read_preg_o", 32'(rs1_seen[1]),
                            32'(rs1_of_rob[ea.rob_idx]));
            end
        end
        if (!rst && data_issue) begin
            if (data_exp_q.size() == 0) begin
                stop_with_failure("data issue came out with no expected record");
            end else begin
                ed = data_exp_q.pop_front();
                check_value("data_issue_payload_o.sq_idx", 32'(data_issue_payload.sq_idx),
                            32'(ed.sq_idx));
                check_value("data_issue_payload_o.size", 32'(data_issue_payload.size),
                            32'(ed.size));
                check_value("data_issue_payload_o.rob_idx", 32'(data_issue_payload.rob_idx),
                            32'(ed.rob_idx));
                check_value("rs2_read_preg_o", 32'(rs2_seen[1]),
                            32'(rs2_of_rob[ed.rob_idx]));
            end
        end
        // the read preg only moves at a rising edge, two samples back is the accepted read
        rs1_seen[1] = rs1_seen[0];
        rs1_seen[0] = rs1_read_preg;
        rs2_seen[1] = rs2_seen[0];
        rs2_seen[0] = rs2_read_preg;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            stop_with_failure("timeout, the run went past its cycle limit");
        end
    end

    initial begin
        int          fd;
        int          lines;
        int          status;
        int          drain;
        string       c;
        string       skip;
        logic [31:0] word;
        rst            = 1'b1;
        dispatch       = 1'b0;
        rs1_ready      = 1'b0;
        rs2_ready      = 1'b0;
        rs1            = '0;
        rs2            = '0;
        rob_idx        = '0;
        sq_idx         = '0;
        memop          = '0;
        imm            = '0;
        wakeup_en      = '0;
        wakeup_preg    = '0;
        redirect       = 1'b0;
        redirect_rob   = '0;
        rs1_read_ready = 1'b1;
        rs2_read_ready = 1'b1;
        stall          = 1'b0;
        lfsr           = 32'haece;
        cycle_count    = 0;
        cycle_limit    = 0;
        lines          = 0;

        fd = $fopen("store_iq_golden.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open store_iq_golden.txt");
        end
        while ($fscanf(fd, "%s", c) == 1) begin
            lines++;
            if (c.substr(0, 0) == "#") begin
                status = $fgets(skip, fd); // rest of a comment line
            end else begin
                cmd_q.push_back(c);
                for (int j = 0; j < 8; j++) begin
                    word = '0;
                    if (j < arg_count(c)) begin
                        status = $fscanf(fd, "%h", word);
                        if (status != 1) begin
                            stop_with_failure("golden file line is missing a field");
                        end
                    end
                    arg_q.push_back(word);
                end
            end
        end
        $fclose(fd);
        cycle_limit = 4 * lines + 100;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int k = 0; k < cmd_q.size(); k++) begin
            run_command(k);
        end

        // let the pipelines drain, then watch a few more cycles for strays
        drain = 0;
        while ((addr_exp_q.size() != 0 || data_exp_q.size() != 0) && drain < 50) begin
            next_cycle();
            drain++;
        end
        repeat (4) next_cycle();

        if (addr_exp_q.size() != 0 || data_exp_q.size() != 0) begin
            stop_with_failure("expected issue missing");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: store_issue_queue_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module store_issue_queue_assertions (
    input wire logic clk,
    input wire logic rst,
    input wire logic redirect_i,
    input wire logic rs1_read_en_i,
    input wire logic rs1_read_ready_i,
    input wire logic rs2_read_en_i,
    input wire logic rs2_read_ready_i,
    input wire logic addr_issue_i,
    input wire logic data_issue_i,
    input wire logic full_i
);

    quiet_in_reset: assert property (@(posedge clk) rst |->
        !(addr_issue_i || data_issue_i || rs1_read_en_i || rs2_read_en_i || full_i))
        else $error("outputs active while reset is held");

    no_read_on_redirect: assert property (@(posedge clk) disable iff (rst)
        redirect_i |-> !rs1_read_en_i && !rs2_read_en_i)
        else $error("read request raised during a redirect");

    // a second pulse needs a second accepted read behind it
    addr_single_pulse: assert property (@(posedge clk) disable iff (rst)
        addr_issue_i |=> !addr_issue_i || $past(rs1_read_en_i && rs1_read_ready_i, 2))
        else $error("addr issue held without a following read");

    data_single_pulse: assert property (@(posedge clk) disable iff (rst)
        data_issue_i |=> !data_issue_i || $past(rs2_read_en_i && rs2_read_ready_i, 2))
        else $error("data issue held without a following read");

    addr_issue_origin: assert property (@(posedge clk) disable iff (rst)
        addr_issue_i |-> $past(rs1_read_en_i && rs1_read_ready_i, 2))
        else $error("addr issue without an rs1 read two edges earlier");

endmodule

bind store_issue_queue store_issue_queue_assertions asrt0 (
    .clk              (clk),
    .rst              (rst),
    .redirect_i       (redirect_i),
    .rs1_read_en_i    (rs1_read_en_o),
    .rs1_read_ready_i (rs1_read_ready_i),
    .rs2_read_en_i    (rs2_read_en_o),
    .rs2_read_ready_i (rs2_read_ready_i),
    .addr_issue_i     (addr_issue_o),
    .data_issue_i     (data_issue_o),
    .full_i           (full_o)
);

`default_nettype wire

// File: store_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module store_issue_queue
    import store_iq_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     dispatch_i,
    input  logic                     rs1_ready_i,
    input  logic                     rs2_ready_i,
    input  preg_t                    rs1_i,
    input  preg_t                    rs2_i,
    input  rob_idx_t                 rob_idx_i,
    input  sq_idx_t                  sq_idx_i,
    input  logic [1:0]               memop_i,
    input  logic [IMM_W-1:0]         imm_i,
    output logic                     full_o,

    input  logic [WAKEUP_PORTS-1:0]  wakeup_en_i,
    input  preg_t [WAKEUP_PORTS-1:0] wakeup_preg_i,

    input  logic                     redirect_i,
    input  rob_idx_t                 redirect_rob_i,

    output logic                     rs1_read_en_o,
    output preg_t                    rs1_read_preg_o,
    input  logic                     rs1_read_ready_i,

    output logic                     rs2_read_en_o,
    output preg_t                    rs2_read_preg_o,
    input  logic                     rs2_read_ready_i,

    output logic                     addr_issue_o,
    output addr_payload_t            addr_issue_payload_o,
    output logic                     data_issue_o,
    output data_payload_t            data_issue_payload_o
);

    mem_size_t     size;
    addr_payload_t addr_payload;
    data_payload_t data_payload;
    logic          addr_full;
    logic          data_full;
    logic          alloc;

    always_comb begin
        case (memop_i)
            MEMOP_SW: size = 2'd2;
            MEMOP_SH: size = 2'd1;
            MEMOP_SB: size = 2'd0;
            default:  size = 2'd0; // unused code, treated as a byte store
        endcase
    end

    assign addr_payload.imm     = imm_i;
    assign addr_payload.sq_idx  = sq_idx_i;
    assign addr_payload.size    = size;
    assign addr_payload.rob_idx = rob_idx_i;

    assign data_payload.sq_idx  = sq_idx_i;
    assign data_payload.size    = size;
    assign data_payload.rob_idx = rob_idx_i;

    // both halves go in together or the store waits
    assign full_o = addr_full | data_full;
    assign alloc  = dispatch_i & ~full_o;

    store_issue_bank #(
        .payload_t (addr_payload_t)
    ) addr_bank (
        .clk                   (clk),
        .rst                   (rst),
        .alloc_i               (alloc),
        .alloc_operand_ready_i (rs1_ready_i),
        .alloc_preg_i          (rs1_i),
        .alloc_payload_i       (addr_payload),
        .full_o                (addr_full),
        .wakeup_en_i           (wakeup_en_i),
        .wakeup_preg_i         (wakeup_preg_i),
        .redirect_i            (redirect_i),
        .redirect_rob_i        (redirect_rob_i),
        .read_en_o             (rs1_read_en_o),
        .read_preg_o           (rs1_read_preg_o),
        .read_ready_i          (rs1_read_ready_i),
        .issue_o               (addr_issue_o),
        .issue_payload_o       (addr_issue_payload_o)
    );

    store_issue_bank #(
        .payload_t (data_payload_t)
    ) data_bank (
        .clk                   (clk),
        .rst                   (rst),
        .alloc_i               (alloc),
        .alloc_operand_ready_i (rs2_ready_i),
        .alloc_preg_i          (rs2_i),
        .alloc_payload_i       (data_payload),
        .full_o                (data_full),
        .wakeup_en_i           (wakeup_en_i),
        .wakeup_preg_i         (wakeup_preg_i),
        .redirect_i            (redirect_i),
        .redirect_rob_i        (redirect_rob_i),
        .read_en_o             (rs2_read_en_o),
        .read_preg_o           (rs2_read_preg_o),
        .read_ready_i          (rs2_read_ready_i),
        .issue_o               (data_issue_o),
        .issue_payload_o       (data_issue_payload_o)
    );

endmodule

`default_nettype wire

// File: store_issue_bank.sv
`timescale 1ns/1ps
`default_nettype none

module store_issue_bank
    import store_iq_pkg::*;
#(
    parameter type payload_t = data_payload_t
) (
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         alloc_i,
    input  logic                         alloc_operand_ready_i,
    input  preg_t                        alloc_preg_i,
    input  payload_t                     alloc_payload_i,
    output logic                         full_o,

    input  logic [WAKEUP_PORTS-1:0]      wakeup_en_i,
    input  preg_t [WAKEUP_PORTS-1:0]     wakeup_preg_i,

    input  logic                         redirect_i,
    input  rob_idx_t                     redirect_rob_i,

    output logic                         read_en_o,
    output preg_t                        read_preg_o,
    input  logic                         read_ready_i,

    output logic                         issue_o,
    output payload_t                     issue_payload_o
);

    logic [BANK_SIZE-1:0] valid_q;
    logic [BANK_SIZE-1:0] opr_ready_q;
    preg_t                preg_q [BANK_SIZE];
    payload_t             payload_q [BANK_SIZE];

    logic [BANK_SIZE-1:0] free_onehot;
    bank_idx_t            free_idx;
    logic                 alloc_take;
    logic [BANK_SIZE-1:0] keep;
    logic [BANK_SIZE-1:0] wake_hit;
    logic [BANK_SIZE-1:0] ready;
    logic [BANK_SIZE-1:0] select;
    bank_idx_t            sel_idx;
    logic                 accept;

    logic                 s1_valid_q;
    logic                 s2_valid_q;
    payload_t             s1_payload_q;
    payload_t             s2_payload_q;
    logic                 s1_kill;

    assign full_o = &valid_q;

    // a store younger than a redirect in the same cycle is wrong path
    assign alloc_take = alloc_i & ~full_o &
                        (~redirect_i | rob_older(alloc_payload_i.rob_idx, redirect_rob_i));

    // lowest free slot, scanning down so the last hit wins
    always_comb begin
        free_onehot = '0;
        free_idx    = '0;
        for (int i = BANK_SIZE - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_onehot    = '0;
                free_onehot[i] = 1'b1;
                free_idx       = bank_idx_t'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < BANK_SIZE; i++) begin
            keep[i]     = rob_older(payload_q[i].rob_idx, redirect_rob_i);
            wake_hit[i] = 1'b0;
            for (int j = 0; j < WAKEUP_PORTS; j++) begin
                if (wakeup_en_i[j] && (wakeup_preg_i[j] == preg_q[i])) begin
                    wake_hit[i] = 1'b1;
                end
            end
        end
    end

    assign ready = valid_q & opr_ready_q;

    oldest_selector age_sel (
        .clk            (clk),
        .rst            (rst),
        .alloc_i        (alloc_take),
        .alloc_onehot_i (free_onehot),
        .ready_i        (ready),
        .select_o       (select)
    );

    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < BANK_SIZE; i++) begin
            if (select[i]) begin
                sel_idx = bank_idx_t'(i);
            end
        end
    end

    assign read_en_o   = (|ready) & ~redirect_i;
    assign read_preg_o = preg_q[sel_idx];
    assign accept      = read_en_o & read_ready_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q     <= '0;
            opr_ready_q <= '0;
        end else begin
            for (int i = 0; i < BANK_SIZE; i++) begin
                if (alloc_take && free_onehot[i]) begin
                    valid_q[i]     <= 1'b1;
                    opr_ready_q[i] <= alloc_operand_ready_i; // same-cycle wakeup is missed
                end else begin
                    valid_q[i]     <= valid_q[i] & ~(accept & select[i]) &
                                      ~(redirect_i & ~keep[i]);
                    opr_ready_q[i] <= opr_ready_q[i] | wake_hit[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_take) begin
            preg_q[free_idx]    <= alloc_preg_i;
            payload_q[free_idx] <= alloc_payload_i;
        end
    end

    // stage 1 holds the payload of the read accepted at the last edge
    assign s1_kill = redirect_i & ~rob_older(s1_payload_q.rob_idx, redirect_rob_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= accept; // no accept can happen under redirect
            s2_valid_q <= s1_valid_q & ~s1_kill;
        end
    end

    always_ff @(posedge clk) begin
        s1_payload_q <= payload_q[sel_idx];
        s2_payload_q <= s1_payload_q;
    end

    assign issue_o         = s2_valid_q;
    assign issue_payload_o = s2_payload_q;

endmodule

`default_nettype wire

// File: oldest_selector.sv
`timescale 1ns/1ps
`default_nettype none

module oldest_selector
    import store_iq_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc_i,
    input  logic [BANK_SIZE-1:0] alloc_onehot_i,
    input  logic [BANK_SIZE-1:0] ready_i,
    output logic [BANK_SIZE-1:0] select_o
);

    // older_q[i][j] set means slot j was allocated before slot i
    logic [BANK_SIZE-1:0] older_q [BANK_SIZE];

    // an entry wins when no older entry is also ready
    always_comb begin
        for (int i = 0; i < BANK_SIZE; i++) begin
            select_o[i] = ready_i[i] & ~(|(older_q[i] & ready_i));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BANK_SIZE; i++) begin
                older_q[i] <= '0;
            end
        end else if (alloc_i) begin
            for (int i = 0; i < BANK_SIZE; i++) begin
                if (alloc_onehot_i[i]) begin
                    older_q[i] <= ~alloc_onehot_i; // every other slot counts as older
                end else begin
                    older_q[i] <= older_q[i] & ~alloc_onehot_i;
                end
            end
        end
    end

    // stale bits from freed slots are harmless
    // they only matter once that slot is ready again, and by then the
    // column has been cleared by its new allocation

endmodule

`default_nettype wire

// File: store_iq_pkg.sv
`default_nettype none

package store_iq_pkg;

    localparam int BANK_SIZE    = 8;
    localparam int BANK_IDX_W   = 3;
    localparam int WAKEUP_PORTS = 2;
    localparam int PREG_W       = 7;
    localparam int SQ_IDX_W     = 5;
    localparam int IMM_W        = 12;
    localparam int ROB_POS_W    = 5;

    localparam logic [1:0] MEMOP_SB = 2'd0;
    localparam logic [1:0] MEMOP_SH = 2'd1;
    localparam logic [1:0] MEMOP_SW = 2'd2;

    typedef logic [PREG_W-1:0]     preg_t;
    typedef logic [SQ_IDX_W-1:0]   sq_idx_t;
    typedef logic [BANK_IDX_W-1:0] bank_idx_t;
    typedef logic [1:0]            mem_size_t; // log2 of the bytes written

    typedef struct packed {
        logic                 dir; // flips each time the ROB wraps
        logic [ROB_POS_W-1:0] pos;
    } rob_idx_t;

    typedef struct packed {
        logic [IMM_W-1:0] imm;
        sq_idx_t          sq_idx;
        mem_size_t        size;
        rob_idx_t         rob_idx;
    } addr_payload_t;

    typedef struct packed {
        sq_idx_t   sq_idx;
        mem_size_t size;
        rob_idx_t  rob_idx;
    } data_payload_t;

    // true when entry is strictly older than the redirect point
    function automatic logic rob_older(input rob_idx_t entry, input rob_idx_t redirect);
        return (entry.dir ^ redirect.dir) ^ (entry.pos < redirect.pos);
    endfunction

endpackage

`default_nettype wire
